//--- filelist.f
+incdir+src
src/usb_rx_pkg.sv
src/usb_line_sampler.sv
src/usb_bit_unstuff.sv
src/usb_pkt_decoder.sv
src/usb_crc_check.sv
src/usb_pkt_rx.sv
verification/tb_clock_gen.sv
verification/usb_pkt_rx_tb.sv

//--- Makefile
# Verilator build and run of the USB packet receiver testbench.
# A failing run ends in $fatal, which gives a non-zero exit status.

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module usb_pkt_rx_tb -o sim_usb_pkt_rx
	./obj_dir/sim_usb_pkt_rx

clean:
	rm -rf obj_dir

//--- verification/usb_pkt_rx_tb.sv
`include "usb_rx_defs.svh"

module usb_pkt_rx_tb
  import usb_rx_pkg::*;
();

  // Number of packets sent, which sizes the watchdog.
  localparam int NUM_PACKETS   = 8;
  localparam int CLK_PERIOD    = 8;
  localparam int EOP_WAIT      = 64;
  // Idle, SYNC, PID, payload, CRC16 with worst case stuffing, then EOP.
  localparam int MAX_LINE_BITS = 2 + ((`USB_MAX_PKT + 4) * 8 * 7) / 6 + 3;
  localparam int PKT_TIME      = (MAX_LINE_BITS * 4 + EOP_WAIT) * CLK_PERIOD;
  localparam int WATCHDOG_TIME = (NUM_PACKETS + 1) * PKT_TIME * 2;

  logic       clk_48MHz;
  logic       arst_n;
  logic       dp;
  logic       dn;
  logic       strobe_12MHz;
  rx_frame_t  frame;
  rx_status_t status;
  token_t     token;
  data_t      data;
  nbytes_t    data_nbytes;

  string      test_name = "reset";
  integer     seed = 32'hd49f3c40;
  logic [7:0] tx_bytes[$];
  logic [7:0] payload_q[$];
  int         sop_count = 0;
  int         eop_count = 0;
  int         strobe_count = 0;
  bit         in_packet = 1'b0;

  tb_clock_gen u_clock_gen (
    .o_clk_48MHz (clk_48MHz),
    .o_arst_n    (arst_n)
  );

  usb_pkt_rx u_usb_pkt_rx (
    .i_clk_48MHz    (clk_48MHz),
    .i_arst_n       (arst_n),
    .i_dp           (dp),
    .i_dn           (dn),
    .o_strobe_12MHz (strobe_12MHz),
    .o_frame        (frame),
    .o_status       (status),
    .o_token        (token),
    .o_data         (data),
    .o_data_nbytes  (data_nbytes)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      abort_run($sformatf("[ERROR] %s: %s expected %0h actual %0h",
                          test_name, what, expected, actual));
    end
  endtask

  // Token CRC5 in reflected form with the result already inverted for the wire.
  function automatic logic [4:0] token_crc5(input logic [10:0] field);
    logic [4:0] crc;
    crc = 5'h1F;
    for (int i = 0; i < 11; i++) begin
      if (crc[0] ^ field[i]) begin
        crc = (crc >> 1) ^ 5'h14;
      end else begin
        crc = crc >> 1;
      end
    end
    return ~crc;
  endfunction

  // One payload byte through the reflected CRC16, LSB first.
  function automatic logic [15:0] crc16_step(input logic [15:0] crc_in, input logic [7:0] b);
    logic [15:0] crc;
    crc = crc_in;
    for (int i = 0; i < 8; i++) begin
      if (crc[0] ^ b[i]) begin
        crc = (crc >> 1) ^ 16'hA001;
      end else begin
        crc = crc >> 1;
      end
    end
    return crc;
  endfunction

  // Holds one line state for a full bit cell of four clocks.
  task automatic drive_state(input line_e state);
    {dp, dn} = state;
    repeat (4) @(negedge clk_48MHz);
  endtask

  // Stuff, NRZI encode and drive tx_bytes, then wait for the end of packet.
  task automatic send_and_wait();
    logic  bits[$];
    int    ones;
    line_e level;
    int    sops_before;
    int    eops_before;
    int    strobes_before;
    int    waited;
    ones = 0;
    foreach (tx_bytes[n]) begin
      for (int i = 0; i < 8; i++) begin
        bits.push_back(tx_bytes[n][i]);
        ones = tx_bytes[n][i] ? ones + 1 : 0;
        // Six ones in a row force a zero.
        if (ones == 6) begin
          bits.push_back(1'b0);
          ones = 0;
        end
      end
    end
    sops_before    = sop_count;
    eops_before    = eop_count;
    strobes_before = strobe_count;
    @(negedge clk_48MHz);
    drive_state(LINE_J);
    drive_state(LINE_J);
    level = LINE_J;
    // A zero toggles the line, a one holds it.
    foreach (bits[i]) begin
      if (!bits[i]) begin
        level = (level == LINE_J) ? LINE_K : LINE_J;
      end
      drive_state(level);
    end
    drive_state(LINE_SE0);
    drive_state(LINE_SE0);
    drive_state(LINE_J);
    waited = 0;
    while ((eop_count == eops_before) && (waited < EOP_WAIT)) begin
      @(negedge clk_48MHz);
      waited++;
    end
    assert (eop_count != eops_before) else begin
      abort_run($sformatf("%s: no end of packet was seen after the line went idle",
                          test_name));
    end
    check_value("sop count", 32'd1, 32'(sop_count - sops_before));
    check_value("eop count", 32'd1, 32'(eop_count - eops_before));
    // One bit strobe per cell after SYNC, up to and including the second SE0.
    check_value("bit strobes", 32'(bits.size() - 8 + 2),
                32'(strobe_count - strobes_before));
  endtask

  // SYNC, PID, then address and endpoint with their CRC5.
  task automatic build_token(input pid_e pid, input logic [6:0] addr,
                             input logic [3:0] endp, input logic [4:0] crc_flip);
    logic [10:0] field;
    logic [4:0]  crc;
    field = {endp, addr};
    crc   = token_crc5(field) ^ crc_flip;
    tx_bytes = {};
    tx_bytes.push_back(8'h80);
    tx_bytes.push_back({~pid, pid});
    tx_bytes.push_back(field[7:0]);
    tx_bytes.push_back({crc, field[10:8]});
  endtask

  // Sends payload_q as a data packet and checks every returned field.
  task automatic run_data_packet(input pid_e pid);
    logic [15:0] crc;
    crc = 16'hFFFF;
    tx_bytes = {};
    tx_bytes.push_back(8'h80);
    tx_bytes.push_back({~pid, pid});
    foreach (payload_q[i]) begin
      tx_bytes.push_back(payload_q[i]);
      crc = crc16_step(crc, payload_q[i]);
    end
    // The CRC goes out inverted with the low byte first.
    crc = ~crc;
    tx_bytes.push_back(crc[7:0]);
    tx_bytes.push_back(crc[15:8]);
    send_and_wait();
    check_value("pid", 32'(pid), 32'(status.pid));
    check_value("pid_ok", 32'd1, 32'(status.pid_ok));
    check_value("data_ok", 32'd1, 32'(status.data_ok));
    check_value("data_nbytes", 32'(payload_q.size()), 32'(data_nbytes));
    foreach (payload_q[i]) begin
      check_value($sformatf("data byte %0d", i), 32'(payload_q[i]), 32'(data[i]));
    end
  endtask

  task automatic idle_after_reset();
    test_name = "reset_state";
    repeat (8) begin
      @(negedge clk_48MHz);
      check_value("o_frame", 32'd0, 32'(frame));
      check_value("pid_ok", 32'd0, 32'(status.pid_ok));
    end
  endtask

  task automatic out_token_fields();
    test_name = "out_token";
    build_token(PID_OUT, 7'h3A, 4'h5, 5'd0);
    send_and_wait();
    check_value("pid", 32'(PID_OUT), 32'(status.pid));
    check_value("pid_ok", 32'd1, 32'(status.pid_ok));
    check_value("token_ok", 32'd1, 32'(status.token_ok));
    check_value("addr", 32'h3A, 32'(token.addr));
    check_value("endp", 32'h5, 32'(token.endp));
  endtask

  task automatic out_token_bad_crc5();
    test_name = "out_bad_crc5";
    build_token(PID_OUT, 7'h3A, 4'h5, 5'b00100);
    send_and_wait();
    check_value("pid", 32'(PID_OUT), 32'(status.pid));
    check_value("pid_ok", 32'd1, 32'(status.pid_ok));
    check_value("token_ok", 32'd0, 32'(status.token_ok));
  endtask

  task automatic data0_random_payload();
    integer rnd;
    int     len;
    test_name = "data0_random";
    repeat (3) begin
      rnd = $random(seed);
      len = 1 + int'($unsigned(rnd) % `USB_MAX_PKT);
      payload_q = {};
      for (int i = 0; i < len; i++) begin
        rnd = $random(seed);
        payload_q.push_back(rnd[7:0]);
      end
      run_data_packet(PID_DATA0);
    end
  endtask

  // All ones payload makes the sender stuff a zero every six bits.
  task automatic data1_all_ones_payload();
    test_name = "data1_stuffing";
    payload_q = {};
    for (int i = 0; i < `USB_MAX_PKT; i++) begin
      payload_q.push_back(8'hFF);
    end
    run_data_packet(PID_DATA1);
  endtask

  task automatic ack_handshake();
    test_name = "ack";
    tx_bytes = {};
    tx_bytes.push_back(8'h80);
    tx_bytes.push_back({~PID_ACK, PID_ACK});
    send_and_wait();
    check_value("pid", 32'(PID_ACK), 32'(status.pid));
    check_value("pid_ok", 32'd1, 32'(status.pid_ok));
  endtask

  // Upper nibble 1010 is not the complement of ACK.
  task automatic corrupt_pid_byte();
    test_name = "bad_pid";
    tx_bytes = {8'h80, 8'hA2};
    send_and_wait();
    check_value("pid", 32'(PID_ACK), 32'(status.pid));
    check_value("pid_ok", 32'd0, 32'(status.pid_ok));
  endtask

  // Framing monitor sampled mid cycle.
  always @(negedge clk_48MHz) begin
    if (arst_n) begin
      assert (!(frame.sop && frame.eop)) else begin
        abort_run("Start and end of packet were flagged in the same cycle.");
      end
      if (strobe_12MHz && frame.in_flight) begin
        strobe_count++;
      end
      if (frame.sop) begin
        assert (!in_packet && !frame.in_flight) else begin
          abort_run("A start of packet was flagged inside a packet.");
        end
        in_packet = 1'b1;
        sop_count++;
      end else if (frame.eop) begin
        assert (in_packet && !frame.in_flight) else begin
          abort_run("An end of packet was flagged with no packet in flight.");
        end
        in_packet = 1'b0;
        eop_count++;
      end else begin
        check_value("in_flight", 32'(in_packet), 32'(frame.in_flight));
      end
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    abort_run("Timeout: the tests ran longer than the packets allow.");
  end

  initial begin
    // Idle bus is J.
    dp = 1'b1;
    dn = 1'b0;
    wait (arst_n === 1'b1);
    idle_after_reset();
    out_token_fields();
    out_token_bad_crc5();
    data0_random_payload();
    data1_all_ones_payload();
    ack_handshake();
    corrupt_pid_byte();
    $display("TEST OK");
    $finish;
  end

endmodule

//--- verification/tb_clock_gen.sv
module tb_clock_gen (
  output logic o_clk_48MHz,
  output logic o_arst_n
);

  // Eight time units per 48 MHz cycle.
  initial begin
    o_clk_48MHz = 1'b0;
    forever #4 o_clk_48MHz = ~o_clk_48MHz;
  end

  // Reset held for three cycles, released away from the rising edge.
  initial begin
    o_arst_n = 1'b0;
    repeat (3) @(posedge o_clk_48MHz);
    @(negedge o_clk_48MHz);
    o_arst_n = 1'b1;
  end

endmodule

//--- src/usb_pkt_rx.sv
module usb_pkt_rx
  import usb_rx_pkg::*;
(
  input  logic       i_clk_48MHz,
  input  logic       i_arst_n,
  input  logic       i_dp,
  input  logic       i_dn,
  output logic       o_strobe_12MHz,
  output rx_frame_t  o_frame,
  output rx_status_t o_status,
  output token_t     o_token,
  output data_t      o_data,
  output nbytes_t    o_data_nbytes
);

  logic        sample;
  line_e [2:0] line_hist;
  rx_frame_t   frame;
  rx_bit_t     rx_bit;
  pid_e        pid;
  logic        pid_ok;
  logic        past_pid;
  logic        token_ok;
  logic        data_ok;

  // Pins to framing and sampled line states.
  usb_line_sampler u_line_sampler (
    .i_clk_48MHz    (i_clk_48MHz),
    .i_arst_n       (i_arst_n),
    .i_dp           (i_dp),
    .i_dn           (i_dn),
    .o_strobe_12MHz (o_strobe_12MHz),
    .o_sample       (sample),
    .o_line_hist    (line_hist),
    .o_frame        (frame)
  );

  // NRZI decode, stuffed bits dropped.
  usb_bit_unstuff u_bit_unstuff (
    .i_clk_48MHz (i_clk_48MHz),
    .i_arst_n    (i_arst_n),
    .i_sample    (sample),
    .i_line_hist (line_hist),
    .i_frame     (frame),
    .o_bit       (rx_bit)
  );

  usb_pkt_decoder u_pkt_decoder (
    .i_clk_48MHz   (i_clk_48MHz),
    .i_arst_n      (i_arst_n),
    .i_bit         (rx_bit),
    .i_frame       (frame),
    .o_pid         (pid),
    .o_pid_ok      (pid_ok),
    .o_past_pid    (past_pid),
    .o_token       (o_token),
    .o_data        (o_data),
    .o_data_nbytes (o_data_nbytes)
  );

  usb_crc_check u_crc_check (
    .i_clk_48MHz (i_clk_48MHz),
    .i_arst_n    (i_arst_n),
    .i_bit       (rx_bit),
    .i_frame     (frame),
    .i_past_pid  (past_pid),
    .o_token_ok  (token_ok),
    .o_data_ok   (data_ok)
  );

  assign o_frame  = frame;
  // Check results only mean something for the matching PID group.
  assign o_status = '{pid: pid, pid_ok: pid_ok, token_ok: token_ok, data_ok: data_ok};

endmodule

//--- src/usb_crc_check.sv
`include "usb_rx_defs.svh"

module usb_crc_check
  import usb_rx_pkg::*;
(
  input  logic      i_clk_48MHz,
  input  logic      i_arst_n,
  input  rx_bit_t   i_bit,
  input  rx_frame_t i_frame,
  input  logic      i_past_pid,
  output logic      o_token_ok,
  output logic      o_data_ok
);

  // Feedback taps without the implicit top term.
  localparam logic [4:0]  CRC5_POLY  = 5'b00101;
  localparam logic [15:0] CRC16_POLY = 16'h8005;

  logic [4:0]  crc5_q;
  logic [15:0] crc16_q;
  logic        crc5_fb;
  logic        crc16_fb;
  logic        crc_en;

  // The PID has its own check, so the CRCs start on the next bit.
  assign crc_en = i_bit.valid && i_past_pid;

  assign crc5_fb  = crc5_q[4] ^ i_bit.value;
  assign crc16_fb = crc16_q[15] ^ i_bit.value;

  // Token CRC, x^5 + x^2 + 1.
  always_ff @(posedge i_clk_48MHz or negedge i_arst_n) begin
    if (!i_arst_n) begin
      crc5_q <= '1;
    end else if (i_frame.sop) begin
      crc5_q <= '1;
    end else if (crc_en) begin
      crc5_q <= {crc5_q[3:0], 1'b0} ^ (crc5_fb ? CRC5_POLY : 5'd0);
    end
  end

  // Data CRC, x^16 + x^15 + x^2 + 1.
  always_ff @(posedge i_clk_48MHz or negedge i_arst_n) begin
    if (!i_arst_n) begin
      crc16_q <= '1;
    end else if (i_frame.sop) begin
      crc16_q <= '1;
    end else if (crc_en) begin
      crc16_q <= {crc16_q[14:0], 1'b0} ^ (crc16_fb ? CRC16_POLY : 16'd0);
    end
  end

  // Running the received CRC through leaves a fixed residual.
  assign o_token_ok = (crc5_q == `USB_CRC5_RESIDUAL);
  assign o_data_ok  = (crc16_q == `USB_CRC16_RESIDUAL);

endmodule

//--- src/usb_pkt_decoder.sv
`include "usb_rx_defs.svh"

module usb_pkt_decoder
  import usb_rx_pkg::*;
(
  input  logic      i_clk_48MHz,
  input  logic      i_arst_n,
  input  rx_bit_t   i_bit,
  input  rx_frame_t i_frame,
  output pid_e      o_pid,
  output logic      o_pid_ok,
  output logic      o_past_pid,
  output token_t    o_token,
  output data_t     o_data,
  output nbytes_t   o_data_nbytes
);

  logic [2:0] bit_cnt_q;
  nbytes_t    byte_cnt_q;
  logic [7:0] shift_q;
  logic [7:0] shift_d;
  logic       byte_done;
  logic       take_pid;
  pid_e       pid_q;
  logic       pid_ok_q;
  pid_group_e pid_group;
  logic       is_data;
  logic [7:0] tok0_q;
  logic [2:0] tok1_q;
  nbytes_t    data_idx_q;
  logic       data_start;
  logic       store_byte;
  data_t      data_q;

  // Bits arrive LSB first, so shift in from the top.
  assign shift_d   = {i_bit.value, shift_q[7:1]};
  assign byte_done = i_bit.valid && (bit_cnt_q == 3'd7);

  always_ff @(posedge i_clk_48MHz) begin
    if (i_bit.valid) begin
      shift_q <= shift_d;
    end
  end

  always_ff @(posedge i_clk_48MHz or negedge i_arst_n) begin
    if (!i_arst_n) begin
      bit_cnt_q  <= '0;
      byte_cnt_q <= '0;
    end else if (i_frame.sop) begin
      bit_cnt_q  <= '0;
      byte_cnt_q <= '0;
    end else begin
      if (i_bit.valid) begin
        bit_cnt_q <= bit_cnt_q + 3'd1;
      end
      // Saturates so a babbling packet never looks like a new PID.
      if (byte_done && (byte_cnt_q != '1)) begin
        byte_cnt_q <= byte_cnt_q + 1'b1;
      end
    end
  end

  assign o_past_pid = (byte_cnt_q != '0);

  // Byte 0 is the PID, upper nibble must be its complement.
  assign take_pid = byte_done && (byte_cnt_q == '0);

  always_ff @(posedge i_clk_48MHz) begin
    if (take_pid) begin
      pid_q <= pid_e'(shift_d[3:0]);
    end
  end

  always_ff @(posedge i_clk_48MHz or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pid_ok_q <= 1'b0;
    end else if (i_frame.sop) begin
      pid_ok_q <= 1'b0;
    end else if (take_pid) begin
      pid_ok_q <= (~shift_d[7:4] == shift_d[3:0]);
    end
  end

  assign pid_group = pid_group_e'(pid_q[1:0]);
  assign is_data   = (pid_group == PGRP_DATA);

  // Token fields: ADDR[6:0] and ENDP[0] in byte 1, ENDP[3:1] in byte 2.
  always_ff @(posedge i_clk_48MHz) begin
    if (byte_done && (pid_group == PGRP_TOKEN)) begin
      if (byte_cnt_q == nbytes_t'(1)) begin
        tok0_q <= shift_d;
      end
      if (byte_cnt_q == nbytes_t'(2)) begin
        tok1_q <= shift_d[2:0];
      end
    end
  end

  // Data index restarts as soon as a data PID is seen.
  assign data_start = take_pid && (pid_group_e'(shift_d[1:0]) == PGRP_DATA);
  assign store_byte = byte_done && is_data && !take_pid;

  always_ff @(posedge i_clk_48MHz or negedge i_arst_n) begin
    if (!i_arst_n) begin
      data_idx_q <= '0;
    end else if (data_start) begin
      data_idx_q <= '0;
    end else if (store_byte) begin
      data_idx_q <= data_idx_q + 1'b1;
    end
  end

  // CRC bytes may land in unused lanes.
  always_ff @(posedge i_clk_48MHz) begin
    for (int b = 0; b < `USB_MAX_PKT; b++) begin
      if (store_byte && (data_idx_q == nbytes_t'(b))) begin
        data_q[b] <= shift_d;
      end
    end
  end

  assign o_pid         = pid_q;
  assign o_pid_ok      = pid_ok_q;
  assign o_token       = '{addr: tok0_q[6:0], endp: {tok1_q, tok0_q[7]}};
  assign o_data        = data_q;
  // Count excludes the two CRC16 bytes.
  assign o_data_nbytes = data_idx_q - nbytes_t'(2);

  // Payload plus CRC16 must fit the buffer.
  a_data_idx_max : assert property (@(posedge i_clk_48MHz) disable iff (!i_arst_n)
    data_idx_q <= nbytes_t'(`USB_MAX_PKT + 2));

endmodule

//--- src/usb_bit_unstuff.sv
`include "usb_rx_defs.svh"

module usb_bit_unstuff
  import usb_rx_pkg::*;
(
  input  logic        i_clk_48MHz,
  input  logic        i_arst_n,
  input  logic        i_sample,
  input  line_e [2:0] i_line_hist,
  input  rx_frame_t   i_frame,
  output rx_bit_t     o_bit
);

  logic [`USB_NRZI_MAX_ONES-1:0] ones_q;
  logic                          jk_pair;
  logic                          din;
  logic                          stuffed;

  function automatic logic is_jk(line_e state);
    return (state == LINE_J) || (state == LINE_K);
  endfunction

  // Only a J/K to J/K pair carries a bit, SE0 never does.
  assign jk_pair = is_jk(i_line_hist[1]) && is_jk(i_line_hist[0]);

  // NRZI: a held level is a one, a toggle is a zero.
  assign din = (i_line_hist[1] == i_line_hist[0]);

  // Shift register of recent bits, all ones means the next bit is stuffed.
  always_ff @(posedge i_clk_48MHz or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ones_q <= '0;
    end else if (i_sample) begin
      if (i_frame.sop) begin
        ones_q <= '0;
      end else if (jk_pair && i_frame.in_flight) begin
        // The stuffed zero enters too, which restarts the run.
        ones_q <= {ones_q[`USB_NRZI_MAX_ONES-2:0], din};
      end
    end
  end

  assign stuffed = &ones_q;

  assign o_bit.valid = i_sample && jk_pair && i_frame.in_flight && !stuffed;
  assign o_bit.value = din;

endmodule

//--- src/usb_line_sampler.sv
module usb_line_sampler
  import usb_rx_pkg::*;
(
  input  logic        i_clk_48MHz,
  input  logic        i_arst_n,
  input  logic        i_dp,
  input  logic        i_dn,
  output logic        o_strobe_12MHz,
  output logic        o_sample,
  output line_e [2:0] o_line_hist,
  output rx_frame_t   o_frame
);

  line_e       sync1_q;
  line_e       sync2_q;
  line_e       line_q;
  logic        line_edge;
  logic [1:0]  bit_phase_q;
  logic        sample;
  line_e [2:0] hist_q;
  logic        in_flight_q;
  logic        sop;
  logic        eop_seen;
  logic        eop_q;

  // Two flop synchronizer on the pin pair, then one more stage for edge detection.
  always_ff @(posedge i_clk_48MHz or negedge i_arst_n) begin
    if (!i_arst_n) begin
      sync1_q <= LINE_J;
      sync2_q <= LINE_J;
      line_q  <= LINE_J;
    end else begin
      sync1_q <= line_e'({i_dp, i_dn});
      sync2_q <= sync1_q;
      line_q  <= sync2_q;
    end
  end

  // Any change of line state realigns the bit phase.
  assign line_edge = (sync2_q != line_q);

  always_ff @(posedge i_clk_48MHz or negedge i_arst_n) begin
    if (!i_arst_n) begin
      bit_phase_q <= 2'd0;
    end else if (line_edge) begin
      bit_phase_q <= 2'd0;
    end else begin
      bit_phase_q <= bit_phase_q + 2'd1;
    end
  end

  // Phase 1 lands near the middle of the four cycle bit cell.
  assign sample         = (bit_phase_q == 2'd1);
  assign o_sample       = sample;
  assign o_strobe_12MHz = (bit_phase_q == 2'd2);

  // Last three sampled states, element 0 is the newest.
  always_ff @(posedge i_clk_48MHz or negedge i_arst_n) begin
    if (!i_arst_n) begin
      hist_q[2] <= LINE_J;
      hist_q[1] <= LINE_J;
      hist_q[0] <= LINE_J;
    end else if (sample) begin
      hist_q[2] <= hist_q[1];
      hist_q[1] <= hist_q[0];
      hist_q[0] <= line_q;
    end
  end

  assign o_line_hist = hist_q;

  // End of SYNC is J then K K.
  assign sop = sample && !in_flight_q &&
               (hist_q[2] == LINE_J) && (hist_q[1] == LINE_K) && (hist_q[0] == LINE_K);

  // Two SE0 samples close the packet.
  assign eop_seen = in_flight_q && (hist_q[1] == LINE_SE0) && (hist_q[0] == LINE_SE0);

  always_ff @(posedge i_clk_48MHz or negedge i_arst_n) begin
    if (!i_arst_n) begin
      in_flight_q <= 1'b0;
      eop_q       <= 1'b0;
    end else begin
      // Flopped so downstream logic sees a clean pulse.
      eop_q <= sample && eop_seen;
      if (sample) begin
        if (sop) begin
          in_flight_q <= 1'b1;
        end else if (eop_seen) begin
          in_flight_q <= 1'b0;
        end
      end
    end
  end

  assign o_frame = '{in_flight: in_flight_q, sop: sop, eop: eop_q};

  // Packet start and end are a bit cell apart at least.
  a_sop_eop_excl : assert property (@(posedge i_clk_48MHz) disable iff (!i_arst_n)
    !(sop && eop_q));

endmodule

//--- src/usb_rx_pkg.sv
`include "usb_rx_defs.svh"

package usb_rx_pkg;

  // Line state as {D+, D-}, full speed polarity.
  typedef enum logic [1:0] {
    LINE_SE0 = 2'b00,
    LINE_K   = 2'b01,
    LINE_J   = 2'b10
  } line_e;

  // PID codes as sent in the low nibble.
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SOF   = 4'b0101,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110,
    PID_PRE   = 4'b1100
  } pid_e;

  // Coding group, taken from the low two PID bits.
  typedef enum logic [1:0] {
    PGRP_SPECIAL   = 2'b00,
    PGRP_TOKEN     = 2'b01,
    PGRP_HANDSHAKE = 2'b10,
    PGRP_DATA      = 2'b11
  } pid_group_e;

  // One decoded bit, qualified by a single cycle strobe.
  typedef struct packed {
    logic valid;
    logic value;
  } rx_bit_t;

  // Packet framing from the line sampler.
  typedef struct packed {
    logic in_flight;
    logic sop;
    logic eop;
  } rx_frame_t;

  typedef struct packed {
    pid_e pid;
    logic pid_ok;
    logic token_ok;
    logic data_ok;
  } rx_status_t;

  typedef struct packed {
    logic [6:0] addr;
    logic [3:0] endp;
  } token_t;

  // Payload buffer, byte 0 in the low lane.
  typedef logic [`USB_MAX_PKT-1:0][7:0] data_t;

  // Byte count wide enough for payload plus PID and CRC bytes.
  typedef logic [$clog2(`USB_MAX_PKT):0] nbytes_t;

endpackage

//--- src/usb_rx_defs.svh
`ifndef USB_RX_DEFS_SVH
`define USB_RX_DEFS_SVH

// Largest data payload in bytes, wMaxPacketSize.
`define USB_MAX_PKT 8

// Run of ones after which the transmitter inserts a zero.
`define USB_NRZI_MAX_ONES 6

// CRC5 register after a token with a good CRC.
`define USB_CRC5_RESIDUAL 5'b01100

// CRC16 register after a data packet with a good CRC.
`define USB_CRC16_RESIDUAL 16'h800D

`endif
